//--- rtl/mmr_macros.svh
`ifndef MMR_MACROS_SVH
`define MMR_MACROS_SVH

// Host bus
`define MMR_ADDR_W 16
`define MMR_DATA_W 32

// Device map, index is the address device field
`define MMR_DEV_MEM   0
`define MMR_DEV_QSPI  1
`define MMR_DEV_BLINK 2
`define MMR_DEV_COUNT 3

// Read data for an unmapped device
`define MMR_ERR_DATA 32'hDEAD_BEEF

// Scratch RAM words
`define MMR_MEM_DEPTH 256

// aclk cycles per SCK half period
`define QSPI_DIV 2

`define BLINK_RESET_PERIOD 8

`endif

//--- rtl/mmr_pkg.sv
`include "mmr_macros.svh"

package mmr_pkg;

    // Register offset inside one device
    typedef logic [11:0] mmr_offset_t;

    // Address word split into device and offset
    typedef struct packed {
        logic [3:0]  dev;
        mmr_offset_t offset;
    } mmr_addr_fields_t;

    // Host sends raw, crossbar looks at the fields
    typedef union packed {
        logic [`MMR_ADDR_W-1:0] raw;
        mmr_addr_fields_t       fields;
    } mmr_addr_u;

endpackage

//--- rtl/mmr_crossbar.sv
`timescale 1ns/1ps

`include "mmr_macros.svh"

module mmr_crossbar
    import mmr_pkg::*;
(
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  logic                      req_write,
    input  mmr_addr_u                 req_addr,
    input  logic [`MMR_DATA_W-1:0]    req_wdata,
    output logic                      req_ready,
    output logic                      resp_valid,
    output logic [`MMR_DATA_W-1:0]    resp_rdata,
    output logic                      resp_err,
    output logic [`MMR_DEV_COUNT-1:0] dev_sel,
    output logic                      dev_write,
    output mmr_offset_t               dev_offset,
    output logic [`MMR_DATA_W-1:0]    dev_wdata,
    input  logic [`MMR_DATA_W-1:0]    mem_rdata,
    input  logic [`MMR_DATA_W-1:0]    qspi_rdata,
    input  logic [`MMR_DATA_W-1:0]    blink_rdata
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_SEL  = 2'd1;
    localparam logic [1:0] ST_RESP = 2'd2;

    logic [1:0]                state;
    mmr_addr_u                 addr_q;   // Address of the request in flight
    logic [`MMR_DEV_COUNT-1:0] sel_dec;
    logic                      accept;
    logic                      unmapped;

    assign req_ready = (state == ST_IDLE);
    assign accept    = req_valid && req_ready;

    // One-hot device decode, all zero past the last device
    always_comb begin
        sel_dec = '0;
        for (int i = 0; i < `MMR_DEV_COUNT; i++) begin
            sel_dec[i] = (req_addr.fields.dev == 4'(i));
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_SEL;
                    end
                end
                ST_SEL:  state <= ST_RESP;   // Device registers its rdata here
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            dev_sel <= '0;
        end else begin
            dev_sel <= accept ? sel_dec : '0;   // Single-cycle pulse
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q    <= req_addr;
            dev_write <= req_write;
            dev_wdata <= req_wdata;
        end
    end

    assign dev_offset = addr_q.fields.offset;

    assign unmapped   = (addr_q.fields.dev >= 4'(`MMR_DEV_COUNT));
    assign resp_valid = (state == ST_RESP);
    assign resp_err   = resp_valid && unmapped;

    // Read data mux on the latched device field
    always_comb begin
        case (addr_q.fields.dev)
            4'(`MMR_DEV_MEM):   resp_rdata = mem_rdata;
            4'(`MMR_DEV_QSPI):  resp_rdata = qspi_rdata;
            4'(`MMR_DEV_BLINK): resp_rdata = blink_rdata;
            default:            resp_rdata = `MMR_ERR_DATA;
        endcase
    end

endmodule

//--- rtl/mmr_mem.sv
`timescale 1ns/1ps

`include "mmr_macros.svh"

module mmr_mem
    import mmr_pkg::*;
(
    input  logic                   aclk,
    input  logic                   sel,
    input  logic                   write,
    input  mmr_offset_t            offset,
    input  logic [`MMR_DATA_W-1:0] wdata,
    output logic [`MMR_DATA_W-1:0] rdata
);

    localparam int IDX_W = $clog2(`MMR_MEM_DEPTH);

    logic [`MMR_DATA_W-1:0] ram [`MMR_MEM_DEPTH];
    logic [IDX_W-1:0]       idx;

    // Upper offset bits are ignored, so the RAM repeats across the device window
    assign idx = offset[IDX_W-1:0];

    always_ff @(posedge aclk) begin
        if (sel) begin
            rdata <= ram[idx];   // Old word on a write
            if (write) begin
                ram[idx] <= wdata;
            end
        end
    end

endmodule

//--- rtl/qspi_ctrl.sv
`timescale 1ns/1ps

`include "mmr_macros.svh"

module qspi_ctrl
    import mmr_pkg::*;
(
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   sel,
    input  logic                   write,
    input  mmr_offset_t            offset,
    input  logic [`MMR_DATA_W-1:0] wdata,
    output logic [`MMR_DATA_W-1:0] rdata,
    output logic                   sck,
    output logic                   csn,
    input  logic [3:0]             miso,
    output logic [3:0]             mosi
);

    localparam int DIV_W = $clog2(`QSPI_DIV + 1);

    localparam mmr_offset_t OFS_TX     = 12'h000;
    localparam mmr_offset_t OFS_RX     = 12'h001;
    localparam mmr_offset_t OFS_STATUS = 12'h002;

    logic [7:0]       tx_byte;
    logic [7:0]       rx_byte;
    logic             busy;
    logic [DIV_W-1:0] div_cnt;
    logic             nib_cnt;   // 0 for the high nibble
    logic             start;
    logic             half_done;

    assign start     = sel && write && (offset == OFS_TX) && !busy;
    assign half_done = (div_cnt == DIV_W'(`QSPI_DIV - 1));

    assign csn  = !busy;
    assign mosi = !busy ? 4'h0 : (nib_cnt ? tx_byte[3:0] : tx_byte[7:4]);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            sck     <= 1'b0;
            div_cnt <= '0;
            nib_cnt <= 1'b0;
            tx_byte <= 8'h00;
            rx_byte <= 8'h00;
        end else if (start) begin
            busy    <= 1'b1;
            sck     <= 1'b0;
            div_cnt <= '0;
            nib_cnt <= 1'b0;
            tx_byte <= wdata[7:0];
        end else if (busy) begin
            if (half_done) begin
                div_cnt <= '0;
                sck     <= !sck;
                if (!sck) begin
                    rx_byte <= {rx_byte[3:0], miso};   // Rising edge
                end else if (nib_cnt) begin
                    busy    <= 1'b0;   // Last falling edge ends the transfer
                    nib_cnt <= 1'b0;
                end else begin
                    nib_cnt <= 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Register readback
    always_ff @(posedge aclk) begin
        if (sel) begin
            case (offset)
                OFS_TX:     rdata <= {24'h0, tx_byte};
                OFS_RX:     rdata <= {24'h0, rx_byte};
                OFS_STATUS: rdata <= {31'h0, busy};
                default:    rdata <= '0;
            endcase
        end
    end

endmodule

//--- rtl/blink.sv
`timescale 1ns/1ps

`include "mmr_macros.svh"

module blink
    import mmr_pkg::*;
(
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   sel,
    input  logic                   write,
    input  mmr_offset_t            offset,
    input  logic [`MMR_DATA_W-1:0] wdata,
    output logic [`MMR_DATA_W-1:0] rdata,
    output logic                   led
);

    logic [`MMR_DATA_W-1:0] period;   // Half period in aclk cycles
    logic [`MMR_DATA_W-1:0] cnt;
    logic                   period_wr;

    assign period_wr = sel && write && (offset == '0);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            period <= `MMR_DATA_W'(`BLINK_RESET_PERIOD);
            cnt    <= '0;
            led    <= 1'b0;
        end else if (period_wr) begin
            period <= wdata;
            cnt    <= '0;   // Restart the count
        end else if (period != '0) begin
            if (cnt >= period - 1'b1) begin
                cnt <= '0;
                led <= !led;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (sel) begin
            rdata <= (offset == '0) ? period : '0;
        end
    end

endmodule

//--- rtl/mmr_top.sv
`timescale 1ns/1ps

`include "mmr_macros.svh"

module mmr_top
    import mmr_pkg::*;
(
    input  logic                   aclk,
    input  logic                   rst_n,

    // Host request and response
    input  logic                   req_valid,
    input  logic                   req_write,
    input  mmr_addr_u              req_addr,
    input  logic [`MMR_DATA_W-1:0] req_wdata,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic [`MMR_DATA_W-1:0] resp_rdata,
    output logic                   resp_err,

    // QSPI
    output logic                   sck,
    output logic                   csn,
    input  logic [3:0]             miso,
    output logic [3:0]             mosi,

    output logic                   led
);

    logic [`MMR_DEV_COUNT-1:0] dev_sel;
    logic                      dev_write;
    mmr_offset_t               dev_offset;
    logic [`MMR_DATA_W-1:0]    dev_wdata;
    logic [`MMR_DATA_W-1:0]    mem_rdata;
    logic [`MMR_DATA_W-1:0]    qspi_rdata;
    logic [`MMR_DATA_W-1:0]    blink_rdata;

    mmr_crossbar
    crossbar_i (
        .aclk(aclk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .req_ready(req_ready),
        .resp_valid(resp_valid),
        .resp_rdata(resp_rdata),
        .resp_err(resp_err),
        .dev_sel(dev_sel),
        .dev_write(dev_write),
        .dev_offset(dev_offset),
        .dev_wdata(dev_wdata),
        .mem_rdata(mem_rdata),
        .qspi_rdata(qspi_rdata),
        .blink_rdata(blink_rdata)
    );

    mmr_mem
    mem_i (
        .aclk(aclk),
        .sel(dev_sel[`MMR_DEV_MEM]),
        .write(dev_write),
        .offset(dev_offset),
        .wdata(dev_wdata),
        .rdata(mem_rdata)
    );

    qspi_ctrl
    qspi_i (
        .aclk(aclk),
        .rst_n(rst_n),
        .sel(dev_sel[`MMR_DEV_QSPI]),
        .write(dev_write),
        .offset(dev_offset),
        .wdata(dev_wdata),
        .rdata(qspi_rdata),
        .sck(sck),
        .csn(csn),
        .miso(miso),
        .mosi(mosi)
    );

    blink
    blink_i (
        .aclk(aclk),
        .rst_n(rst_n),
        .sel(dev_sel[`MMR_DEV_BLINK]),
        .write(dev_write),
        .offset(dev_offset),
        .wdata(dev_wdata),
        .rdata(blink_rdata),
        .led(led)
    );

endmodule

//--- testbench/mmr_assert.sv
`timescale 1ns/1ps

`include "mmr_macros.svh"

module mmr_assert (
    input logic                      aclk,
    input logic                      rst_n,
    input logic                      req_valid,
    input logic                      req_ready,
    input logic                      resp_valid,
    input logic [`MMR_DEV_COUNT-1:0] dev_sel
);

    logic accept;

    assign accept = req_valid && req_ready;

    resp_latency: assert property (@(posedge aclk) disable iff (!rst_n)
        accept |-> ##2 $rose(resp_valid))
        else $error("resp_valid did not rise two cycles after an accepted request");

    // Host is held off for the select and respond cycles
    ready_low_pending: assert property (@(posedge aclk) disable iff (!rst_n)
        accept |=> !req_ready [*2])
        else $error("req_ready went high while a response was pending");

    // A single select pulse per transaction
    sel_single: assert property (@(posedge aclk) disable iff (!rst_n)
        (dev_sel != '0) |-> $onehot(dev_sel) ##1 (dev_sel == '0) [*2])
        else $error("dev_sel set more than one bit or pulsed twice for one request");

endmodule

bind mmr_crossbar mmr_assert assert_i (
    .aclk(aclk),
    .rst_n(rst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .resp_valid(resp_valid),
    .dev_sel(dev_sel)
);

//--- testbench/mmr_tb.sv
`timescale 1ns/1ps

`include "mmr_macros.svh"

module mmr_tb
    import mmr_pkg::*;
();

    localparam int N_MEM           = 16;
    localparam int N_XFER          = 4;
    localparam int N_TRANS         = 1 + 2 * N_MEM + 2 * 13 + 2 * N_XFER + 2;
    localparam int WATCHDOG_CYCLES = N_TRANS * 4 + N_XFER * 20 + 1000;

    typedef struct packed {
        logic        err;
        logic [31:0] mask;   // Bits of rdata that are compared
        logic [31:0] data;
    } expect_t;

    typedef struct packed {
        logic        is_write;
        mmr_addr_u   addr;
        logic [31:0] wdata;
        logic [31:0] cycle;
    } pending_t;

    logic                   aclk = 1'b0;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_write;
    mmr_addr_u              req_addr;
    logic [`MMR_DATA_W-1:0] req_wdata;
    logic                   req_ready;
    logic                   resp_valid;
    logic [`MMR_DATA_W-1:0] resp_rdata;
    logic                   resp_err;
    logic                   sck;
    logic                   csn;
    logic [3:0]             miso;
    logic [3:0]             mosi;
    logic                   led;

    logic [31:0] cycle = '0;
    logic [31:0] rng_state = 32'h8059_309d;
    logic [31:0] ram_model [`MMR_MEM_DEPTH];
    bit          ram_valid [`MMR_MEM_DEPTH] = '{default: 1'b0};
    logic [31:0] blink_period_model = `MMR_DATA_W'(`BLINK_RESET_PERIOD);
    logic [7:0]  qspi_tx_model = 8'h00;
    logic [7:0]  qspi_rx_model = 8'h00;
    pending_t    pending_q [$];
    int          resp_errors = 0;
    int          resp_checks = 0;
    int          check_errors = 0;
    int          csn_low_cycles = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;
    string       test_name;

    assign miso = mosi;   // QSPI loopback

    always #20 aclk = !aclk;

    always @(posedge aclk) begin
        cycle <= cycle + 32'd1;
    end

    mmr_top mmr_top_i (
        .aclk(aclk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .req_ready(req_ready),
        .resp_valid(resp_valid),
        .resp_rdata(resp_rdata),
        .resp_err(resp_err),
        .sck(sck),
        .csn(csn),
        .miso(miso),
        .mosi(mosi),
        .led(led)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Expected response from the register map, updating the model on writes
    function automatic expect_t ref_model(input logic wr, input mmr_addr_u addr,
                                          input logic [31:0] wd);
        expect_t e;
        int      idx;
        e.err  = 1'b0;
        e.mask = wr ? 32'h0 : 32'hFFFF_FFFF;
        e.data = 32'h0;
        idx    = int'(addr.fields.offset) % `MMR_MEM_DEPTH;
        case (addr.fields.dev)
            4'(`MMR_DEV_MEM): begin
                if (!ram_valid[idx]) e.mask = 32'h0;
                e.data = ram_model[idx];
                if (wr) begin
                    ram_model[idx] = wd;
                    ram_valid[idx] = 1'b1;
                end
            end
            4'(`MMR_DEV_QSPI): begin
                if (addr.fields.offset == 12'h000) begin
                    if (wr) begin
                        qspi_tx_model = wd[7:0];
                        qspi_rx_model = wd[7:0];   // Loopback returns the same byte
                    end
                    e.data = {24'h0, qspi_tx_model};
                end else if (addr.fields.offset == 12'h001) begin
                    e.data = {24'h0, qspi_rx_model};
                end else if (addr.fields.offset == 12'h002) begin
                    e.mask = e.mask & 32'hFFFF_FFFE;   // Busy depends on timing
                end
            end
            4'(`MMR_DEV_BLINK): begin
                if (addr.fields.offset == 12'h000) begin
                    if (wr) blink_period_model = wd;
                    e.data = blink_period_model;
                end
            end
            default: begin
                e.err  = 1'b1;
                e.data = `MMR_ERR_DATA;
            end
        endcase
        return e;
    endfunction

    always @(negedge aclk) begin
        pending_t p;
        expect_t  e;
        if (rst_n) begin
            if (resp_valid) begin
                if (pending_q.size() == 0) begin
                    $display("A response arrived at %0t ns with no request outstanding", $time);
                    resp_errors++;
                end else begin
                    p = pending_q.pop_front();
                    e = ref_model(p.is_write, p.addr, p.wdata);
                    resp_checks++;
                    assert (cycle - p.cycle == 32'd2) else begin
                        $display("FAILED at %0t ns: latency %0d cycles for addr %h",
                                 $time, cycle - p.cycle, p.addr.raw);
                        resp_errors++;
                    end
                    assert (resp_err == e.err) else begin
                        $display("FAILED at %0t ns: resp_err %b, expected %b for addr %h",
                                 $time, resp_err, e.err, p.addr.raw);
                        resp_errors++;
                    end
                    assert (((resp_rdata ^ e.data) & e.mask) == 32'h0) else begin
                        $display("FAILED at %0t ns: rdata %h, expected %h for addr %h",
                                 $time, resp_rdata, e.data, p.addr.raw);
                        resp_errors++;
                    end
                end
            end
            if (req_valid && req_ready) begin
                p.is_write = req_write;
                p.addr     = req_addr;
                p.wdata    = req_wdata;
                p.cycle    = cycle;
                pending_q.push_back(p);
            end
        end
    end

    always @(negedge aclk) begin
        if (rst_n && !csn) csn_low_cycles++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_condition(input bit ok, input string what);
        assert (ok) else begin
            $display("FAILED at %0t ns: %s", $time, what);
            check_errors++;
        end
    endtask

    // One transaction, returns at the negedge where the response is seen
    task automatic bus_access(input logic wr, input mmr_addr_u addr,
                              input logic [31:0] wd, output logic [31:0] rd);
        @(posedge aclk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wd;
        @(negedge aclk);
        while (!req_ready) @(negedge aclk);
        @(posedge aclk);
        req_valid <= 1'b0;
        do @(negedge aclk); while (!resp_valid);
        rd = resp_rdata;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = resp_errors + check_errors;
        tests_run++;
    endtask

    task automatic end_test();
        int errs;
        @(posedge aclk);   // Let the comparator finish the last response
        errs = resp_errors + check_errors - errors_at_start;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        mmr_addr_u      a;
        mmr_offset_t    offs [N_MEM];
        logic [31:0]    rd;
        logic [31:0]    rnd;
        logic [7:0]     tx;
        int             low_before;
        int unsigned    p;
        logic [31:0]    t_first;
        logic           prev;
        logic           changed;
        int             total;

        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        req_write <= 1'b0;
        req_addr  <= '0;
        req_wdata <= '0;
        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;
        @(negedge aclk);

        begin_test("reset");
        check_condition(req_ready == 1'b1, "req_ready low after reset");
        check_condition(resp_valid == 1'b0, "resp_valid high after reset");
        check_condition(mmr_top_i.crossbar_i.dev_sel == '0, "a sel line high after reset");
        check_condition(csn == 1'b1 && sck == 1'b0 && mosi == 4'h0, "QSPI pins not idle");
        check_condition(led == 1'b0, "led high after reset");
        a.fields.dev    = 4'(`MMR_DEV_BLINK);
        a.fields.offset = 12'h000;
        bus_access(1'b0, a, 32'h0, rd);
        check_condition(rd == `MMR_DATA_W'(`BLINK_RESET_PERIOD), "wrong blink reset period");
        end_test();

        begin_test("ram");
        a.fields.dev = 4'(`MMR_DEV_MEM);
        for (int i = 0; i < N_MEM; i++) begin
            rnd             = next_random();
            offs[i]         = rnd[11:0];
            a.fields.offset = offs[i];
            bus_access(1'b1, a, next_random(), rd);
        end
        for (int i = 0; i < N_MEM; i++) begin
            rnd             = next_random();
            a.fields.offset = offs[i] + 12'(int'(rnd[3:0]) * `MMR_MEM_DEPTH);   // Alias
            bus_access(1'b0, a, 32'h0, rd);
        end
        end_test();

        begin_test("unmapped");
        for (int d = `MMR_DEV_COUNT; d < 16; d++) begin
            rnd             = next_random();
            a.fields.dev    = 4'(d);
            a.fields.offset = rnd[11:0];
            bus_access(1'b1, a, next_random(), rd);
            bus_access(1'b0, a, 32'h0, rd);
        end
        end_test();

        begin_test("qspi");
        a.fields.dev = 4'(`MMR_DEV_QSPI);
        for (int i = 0; i < N_XFER; i++) begin
            rnd             = next_random();
            tx              = rnd[7:0];
            low_before      = csn_low_cycles;
            a.fields.offset = 12'h000;
            bus_access(1'b1, a, {24'h0, tx}, rd);
            a.fields.offset = 12'h002;
            do begin
                bus_access(1'b0, a, 32'h0, rd);
            end while (rd[0]);
            check_condition(csn_low_cycles > low_before, "csn never went low in a transfer");
            a.fields.offset = 12'h001;
            bus_access(1'b0, a, 32'h0, rd);
            check_condition(rd[7:0] == tx, $sformatf("received %h, sent %h", rd[7:0], tx));
        end
        end_test();

        begin_test("blink");
        p               = 3 + next_random() % 8;
        a.fields.dev    = 4'(`MMR_DEV_BLINK);
        a.fields.offset = 12'h000;
        bus_access(1'b1, a, 32'(p), rd);
        prev = led;
        do @(negedge aclk); while (led == prev);
        t_first = cycle;
        prev    = led;
        do @(negedge aclk); while (led == prev);
        check_condition(cycle - t_first == 32'(p),
                        $sformatf("led toggled after %0d cycles, period %0d", cycle - t_first, p));
        bus_access(1'b1, a, 32'h0, rd);
        prev    = led;
        changed = 1'b0;
        repeat (3 * p) begin
            @(negedge aclk);
            if (led != prev) changed = 1'b1;
        end
        check_condition(!changed, "led toggled with a zero period");
        end_test();

        total = resp_errors + check_errors;
        $display("%0d tests, %0d failed, %0d responses checked, %0d errors",
                 tests_run, tests_failed, resp_checks, total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/mmr_pkg.sv
rtl/mmr_crossbar.sv
rtl/mmr_mem.sv
rtl/qspi_ctrl.sv
rtl/blink.sv
rtl/mmr_top.sv
testbench/mmr_assert.sv
testbench/mmr_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mmr_tb -f project.f -o mmr_sim

# An aborted run still reaches the pass check below
output=$(./obj_dir/mmr_sim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Simulation passed"; then
    exit 0
else
    exit 1
fi
